/* verification/codebook_input.txt */
// columns: op address data, hex; op 1 write OKAY, 2 write SLVERR, 3 read compare,
// 4 read SLVERR, 5 poll until done; node data is left << 9 | right, op 0 ends the list
3 004 00000000
3 008 00000000
// balanced tree, A=00 B=01 C=10 D=11
1 400 00020302
1 404 00008242
1 408 00008644
1 008 00000000
1 000 00000001
5 000 00000000
3 004 00000402
3 904 80020000
3 908 80020001
3 90c 80020002
3 910 80020003
3 914 00000000
// zigzag chain at nodes 0x10..0x17, chain steps 0 1 0 1 0 0 1, a..i
1 440 00022261
1 444 0000c512
1 448 00022663
1 44c 0000c914
1 450 00022a65
1 454 00022c66
1 458 0000cf17
1 45c 0000d069
1 008 00000010
3 008 00000010
1 000 00000001
5 000 00000000
3 004 00000902
3 984 80010001
3 988 80020000
3 98c 80030003
3 990 80040004
3 994 8005000b
3 998 80060015
3 99c 80070028
3 9a0 80080052
3 9a4 80080053
// first tree is gone
3 904 00000000
3 910 00000000
// root right child empty, x=00 y=010 z=011; node write during the walk is refused
1 480 00024380
1 484 0000f122
1 488 0000f27a
1 008 00000020
1 000 00000001
2 484 000000c1
5 000 00000000
3 004 00000302
3 9e0 80020000
3 9e4 80030002
3 9e8 80030003
3 984 00000000
3 9a4 00000000
3 800 00000000
3 a00 00000000
// unmapped accesses
4 00c 00000000
4 300 00000000
4 440 00000000
2 010 00000000
0 000 00000000

/* all.f */
hw/huff_pkg.sv
hw/sdp_ram.sv
hw/code_path.sv
hw/tree_walker.sv
hw/axil_regs.sv
hw/huff_codebook_top.sv
verification/tb_clock.sv
verification/cb_checker.sv
verification/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
TOP       ?= tb_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/tb_top.sv */
`default_nettype none

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_RECORDS = 256;
  localparam int WORDS = 3 * MAX_RECORDS;         // op, address and data per record
  localparam int CYCLES_PER_RECORD = 2000;
  localparam logic [1:0] OKAY = 2'b00;
  localparam logic [1:0] SLVERR = 2'b10;
  localparam logic [11:0] STATUS_ADDR = 12'h004;

  logic        clk;
  logic        rst;
  logic [11:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [11:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  logic [31:0] stim [WORDS];
  logic [31:0] rng_state;
  int          n_records;
  int          limit_cycles;

  tb_clock #(.PERIOD_NS(10)) tb_clock_inst (.clk(clk));

  huff_codebook_top huff_codebook_top_inst (
    .clk(clk), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  cb_checker cb_checker_inst (
    .clk(clk), .rst(rst),
    .awvalid(awvalid), .awready(awready), .wvalid(wvalid), .wready(wready),
    .arvalid(arvalid), .arready(arready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
    awaddr = addr;
    wdata = data;
    wstrb = 4'hf;
    awvalid = 1'b1;
    wvalid = 1'b1;
    @(posedge clk);
    while (!(awready && wready)) @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid = 1'b0;
    @(posedge clk);
    while (!(bvalid && bready)) @(posedge clk);
    #1;
  endtask

  task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
    araddr = addr;
    arvalid = 1'b1;
    @(posedge clk);
    while (!arready) @(posedge clk);
    #1;
    arvalid = 1'b0;
    @(posedge clk);
    while (!(rvalid && rready)) @(posedge clk);
    data = rdata;
    #1;
  endtask

  // poll status until the done bit is set
  task automatic wait_done();
    logic [31:0] status;
    status = '0;
    while (!status[1]) begin
      cb_checker_inst.expect_read(STATUS_ADDR, 32'h0, 32'h0, OKAY);
      axi_read(STATUS_ADDR, status);
    end
  endtask

  task automatic run_record(input logic [3:0] op, input logic [11:0] addr,
                            input logic [31:0] data);
    logic [31:0] got;
    case (op)
      4'h1, 4'h2: begin
        cb_checker_inst.expect_write(addr, (op == 4'h1) ? OKAY : SLVERR);
        axi_write(addr, data);
      end
      4'h3: begin
        cb_checker_inst.expect_read(addr, data, 32'hffff_ffff, OKAY);
        axi_read(addr, got);
      end
      4'h4: begin
        cb_checker_inst.expect_read(addr, 32'h0, 32'h0, SLVERR);
        axi_read(addr, got);
      end
      4'h5: wait_done();
      default: cb_checker_inst.report_error($sformatf("data file has unknown op %h", op));
    endcase
  endtask

  task automatic print_summary();
    $display("checks: %0d, errors: %0d", cb_checker_inst.checks, cb_checker_inst.errors);
  endtask

  initial begin : stall
    rng_state = 32'd52951;
    bready = 1'b0;
    rready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      rng_state = xorshift32(rng_state);
      bready = (rng_state[1:0] != 2'b00);        // ready about three cycles in four
      rready = (rng_state[9:8] != 2'b00);
    end
  end

  initial begin : watchdog
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", limit_cycles);
    print_summary();
    $display("Result: FAILED");
    $finish;
  end

  initial begin : main
    int rec;
    rst = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    for (rec = 0; rec < WORDS; rec++) begin
      stim[rec] = '0;
    end
    $readmemh("verification/codebook_input.txt", stim);
    n_records = 0;
    while (n_records < MAX_RECORDS && stim[3 * n_records] != 32'h0) begin
      n_records++;
    end
    limit_cycles = (n_records + 4) * CYCLES_PER_RECORD;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    for (rec = 0; rec < n_records; rec++) begin
      run_record(stim[3 * rec][3:0], stim[3 * rec + 1][11:0], stim[3 * rec + 2]);
    end
    cb_checker_inst.final_check();
    print_summary();
    if (cb_checker_inst.errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/cb_checker.sv */
`default_nettype none

module cb_checker (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        awvalid,
  input  wire logic        awready,
  input  wire logic        wvalid,
  input  wire logic        wready,
  input  wire logic        arvalid,
  input  wire logic        arready,
  input  wire logic [1:0]  bresp,
  input  wire logic        bvalid,
  input  wire logic        bready,
  input  wire logic [31:0] rdata,
  input  wire logic [1:0]  rresp,
  input  wire logic        rvalid,
  input  wire logic        rready
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [11:0] wr_addr_q [$];
  logic [1:0]  wr_resp_q [$];
  logic [11:0] rd_addr_q [$];
  logic [31:0] rd_data_q [$];
  logic [31:0] rd_mask_q [$];                     // zero mask means only rresp is compared
  logic [1:0]  rd_resp_q [$];
  int          checks;
  int          errors;

  task automatic expect_write(input logic [11:0] addr, input logic [1:0] resp);
    wr_addr_q.push_back(addr);
    wr_resp_q.push_back(resp);
  endtask

  task automatic expect_read(input logic [11:0] addr, input logic [31:0] data,
                             input logic [31:0] mask, input logic [1:0] resp);
    rd_addr_q.push_back(addr);
    rd_data_q.push_back(data);
    rd_mask_q.push_back(mask);
    rd_resp_q.push_back(resp);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  task automatic check_write();
    logic [11:0] addr;
    logic [1:0]  exp_resp;
    if (wr_resp_q.size() == 0) begin
      report_error("write response arrived with no write outstanding");
    end else begin
      addr = wr_addr_q.pop_front();
      exp_resp = wr_resp_q.pop_front();
      checks++;
      if (bresp !== exp_resp) begin
        errors++;
        $display("mismatch at %0t ns: bresp (addr %h) expected %h got %h",
                 $time, addr, exp_resp, bresp);
      end
    end
  endtask

  task automatic check_read();
    logic [11:0] addr;
    logic [31:0] exp_data;
    logic [31:0] mask;
    logic [1:0]  exp_resp;
    if (rd_resp_q.size() == 0) begin
      report_error("read response arrived with no read outstanding");
    end else begin
      addr = rd_addr_q.pop_front();
      exp_data = rd_data_q.pop_front();
      mask = rd_mask_q.pop_front();
      exp_resp = rd_resp_q.pop_front();
      checks++;
      if (rresp !== exp_resp) begin
        errors++;
        $display("mismatch at %0t ns: rresp (addr %h) expected %h got %h",
                 $time, addr, exp_resp, rresp);
      end
      if ((rdata & mask) !== (exp_data & mask)) begin
        errors++;
        $display("mismatch at %0t ns: rdata (addr %h) expected %h got %h",
                 $time, addr, exp_data, rdata);
      end
    end
  endtask

  // the write channel accepts address and data together, and only when both are offered
  task automatic check_ready();
    if (awready !== wready) begin
      report_error("awready and wready were not raised together");
    end
    if (awready === 1'b1 && !(awvalid && wvalid)) begin
      report_error("awready raised with no write address and data offered");
    end
    if (arready === 1'b1 && !arvalid) begin
      report_error("arready raised with no read address offered");
    end
  endtask

  // anything still queued at the end is a response that never came back
  task automatic final_check();
    if (wr_resp_q.size() != 0) begin
      report_error($sformatf("%0d write responses never arrived", wr_resp_q.size()));
    end
    if (rd_resp_q.size() != 0) begin
      report_error($sformatf("%0d read responses never arrived", rd_resp_q.size()));
    end
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      check_ready();
    end
    if (!rst && bvalid && bready) begin
      check_write();
    end
    if (!rst && rvalid && rready) begin
      check_read();
    end
  end

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 10
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;                // half period high, half low
    end
  end

endmodule

`default_nettype wire

/* hw/huff_codebook_top.sv */
`default_nettype none

module huff_codebook_top (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic [11:0] awaddr,
  input  wire logic        awvalid,
  output logic             awready,
  input  wire logic [31:0] wdata,
  input  wire logic [3:0]  wstrb,
  input  wire logic        wvalid,
  output logic             wready,
  output logic [1:0]       bresp,
  output logic             bvalid,
  input  wire logic        bready,
  input  wire logic [11:0] araddr,
  input  wire logic        arvalid,
  output logic             arready,
  output logic [31:0]      rdata,
  output logic [1:0]       rresp,
  output logic             rvalid,
  input  wire logic        rready
);
  import huff_pkg::*;

  logic                   start;
  logic [NODE_ADDR_W-1:0] root;
  logic                   node_we;
  logic [NODE_ADDR_W-1:0] node_waddr;
  node_t                  node_wdata;
  logic [NODE_ADDR_W-1:0] node_raddr;
  node_t                  node_rdata;
  logic                   cb_we;
  logic [CHAR_W-1:0]      cb_waddr;
  cb_entry_t              cb_wdata;
  logic [CHAR_W-1:0]      cb_raddr;
  cb_entry_t              cb_rdata;
  logic                   busy;
  logic                   done;
  logic [7:0]             codes;
  logic                   cp_clear;
  logic                   cp_push;
  logic                   cp_dir;
  logic                   cp_pop;
  logic                   rewalk_start;
  logic                   rewalk_step;
  logic [MAX_DEPTH-1:0]   path;
  logic [DEPTH_W-1:0]     depth;
  logic                   rewalk_dir;
  logic                   rewalk_last;

  axil_regs axil_regs_inst (
    .clk(clk), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .start(start), .root(root),
    .node_we(node_we), .node_waddr(node_waddr), .node_wdata(node_wdata),
    .cb_raddr(cb_raddr), .cb_rdata(cb_rdata),
    .busy(busy), .done(done), .codes(codes)
  );

  tree_walker tree_walker_inst (
    .clk(clk), .rst(rst),
    .start(start), .root(root),
    .node_raddr(node_raddr), .node_rdata(node_rdata),
    .cb_we(cb_we), .cb_waddr(cb_waddr), .cb_wdata(cb_wdata),
    .busy(busy), .done(done), .codes(codes),
    .clear(cp_clear), .push(cp_push), .dir(cp_dir), .pop(cp_pop),
    .rewalk_start(rewalk_start), .rewalk_step(rewalk_step),
    .path(path), .depth(depth), .rewalk_dir(rewalk_dir), .rewalk_last(rewalk_last)
  );

  code_path code_path_inst (
    .clk(clk), .rst(rst),
    .clear(cp_clear), .push(cp_push), .dir(cp_dir), .pop(cp_pop),
    .rewalk_start(rewalk_start), .rewalk_step(rewalk_step),
    .path(path), .depth(depth), .rewalk_dir(rewalk_dir), .rewalk_last(rewalk_last)
  );

  // host writes the tree, the walker reads it
  sdp_ram #(.payload_t(node_t), .DEPTH(NODE_COUNT)) node_mem (
    .clk(clk),
    .we(node_we), .waddr(node_waddr), .wdata(node_wdata),
    .raddr(node_raddr), .rdata(node_rdata)
  );

  // walker fills the codebook, the host reads it back
  sdp_ram #(.payload_t(cb_entry_t), .DEPTH(CB_COUNT)) cb_mem (
    .clk(clk),
    .we(cb_we), .waddr(cb_waddr), .wdata(cb_wdata),
    .raddr(cb_raddr), .rdata(cb_rdata)
  );

endmodule

`default_nettype wire

/* hw/axil_regs.sv */
`default_nettype none

module axil_regs (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic [11:0]                   awaddr,
  input  wire logic                          awvalid,
  output logic                               awready,
  input  wire logic [31:0]                   wdata,
  input  wire logic [3:0]                    wstrb,
  input  wire logic                          wvalid,
  output logic                               wready,
  output logic [1:0]                         bresp,
  output logic                               bvalid,
  input  wire logic                          bready,
  input  wire logic [11:0]                   araddr,
  input  wire logic                          arvalid,
  output logic                               arready,
  output logic [31:0]                        rdata,
  output logic [1:0]                         rresp,
  output logic                               rvalid,
  input  wire logic                          rready,
  output logic                               start,
  output logic [huff_pkg::NODE_ADDR_W-1:0]   root,
  output logic                               node_we,
  output logic [huff_pkg::NODE_ADDR_W-1:0]   node_waddr,
  output huff_pkg::node_t                    node_wdata,
  output logic [huff_pkg::CHAR_W-1:0]        cb_raddr,
  input  wire huff_pkg::cb_entry_t           cb_rdata,
  input  wire logic                          busy,
  input  wire logic                          done,
  input  wire logic [7:0]                    codes
);
  import huff_pkg::*;

  logic        wr_hs;
  logic        rd_hs;
  logic [11:0] aw_word;
  logic [11:0] ar_word;
  logic        aw_node;
  logic        aw_cb;
  logic        ar_cb;
  logic        ar_reg;
  logic        cb_pend;                           // codebook RAM read in flight
  logic        done_flag;

  assign wr_hs = awready && awvalid && wready && wvalid;
  assign rd_hs = arready && arvalid;
  assign aw_word = {awaddr[11:2], 2'b00};
  assign ar_word = {araddr[11:2], 2'b00};
  assign aw_node = (awaddr[11:9] == NODE_BASE[11:9]); // 0x400 up to 0x5fc
  assign aw_cb = (awaddr[11:10] == CB_BASE[11:10]);
  assign ar_cb = (araddr[11:10] == CB_BASE[11:10]);
  assign ar_reg = (ar_word == REG_CTRL) || (ar_word == REG_STATUS) || (ar_word == REG_ROOT);

  // the RAM samples the address on the accepting edge
  assign cb_raddr = araddr[CHAR_W+1:2];

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      awready <= 1'b0;
      wready <= 1'b0;
      bvalid <= 1'b0;
      bresp <= RESP_OKAY;
      start <= 1'b0;
      root <= '0;
      node_we <= 1'b0;
      done_flag <= 1'b0;
    end else begin
      awready <= awvalid && wvalid && !awready && !bvalid;
      wready <= awvalid && wvalid && !awready && !bvalid;
      start <= 1'b0;
      node_we <= 1'b0;
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (done) begin
        done_flag <= 1'b1;                        // held until the next start
      end
      if (wr_hs) begin
        bvalid <= 1'b1;
        bresp <= RESP_OKAY;
        if (aw_word == REG_CTRL) begin
          if (wstrb[0] && wdata[0]) begin
            start <= 1'b1;
            done_flag <= 1'b0;
          end
        end else if (aw_word == REG_ROOT) begin
          if (wstrb[0]) begin
            root <= wdata[NODE_ADDR_W-1:0];
          end
        end else if (aw_node) begin
          if (busy) begin
            bresp <= RESP_SLVERR;                 // tree is locked during a walk
          end else begin
            node_we <= &wstrb[2:0];
          end
        end else if (aw_word != REG_STATUS && !aw_cb) begin
          bresp <= RESP_SLVERR;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      node_waddr <= awaddr[NODE_ADDR_W+1:2];
      node_wdata <= node_t'(wdata[$bits(node_t)-1:0]);
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      arready <= 1'b0;
      rvalid <= 1'b0;
      rresp <= RESP_OKAY;
      cb_pend <= 1'b0;
    end else begin
      arready <= arvalid && !arready && !rvalid && !cb_pend;
      cb_pend <= 1'b0;
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
      if (cb_pend) begin
        rvalid <= 1'b1;
        rresp <= RESP_OKAY;
      end
      if (rd_hs) begin
        if (ar_cb) begin
          cb_pend <= 1'b1;                        // one extra cycle for the RAM
        end else begin
          rvalid <= 1'b1;
          rresp <= ar_reg ? RESP_OKAY : RESP_SLVERR;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cb_pend) begin
      rdata <= {cb_rdata.valid, 10'b0, cb_rdata.len, cb_rdata.code};
    end else if (rd_hs) begin
      case (ar_word)
        REG_STATUS: rdata <= {16'b0, codes, 6'b0, done_flag, busy};
        REG_ROOT: rdata <= 32'(root);
        default: rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/tree_walker.sv */
`default_nettype none

module tree_walker (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic                          start,
  input  wire logic [huff_pkg::NODE_ADDR_W-1:0] root,
  output logic [huff_pkg::NODE_ADDR_W-1:0]   node_raddr,
  input  wire huff_pkg::node_t               node_rdata,
  output logic                               cb_we,
  output logic [huff_pkg::CHAR_W-1:0]        cb_waddr,
  output huff_pkg::cb_entry_t                cb_wdata,
  output logic                               busy,
  output logic                               done,
  output logic [7:0]                         codes,
  output logic                               clear,
  output logic                               push,
  output logic                               dir,
  output logic                               pop,
  output logic                               rewalk_start,
  output logic                               rewalk_step,
  input  wire logic [huff_pkg::MAX_DEPTH-1:0] path,
  input  wire logic [huff_pkg::DEPTH_W-1:0]  depth,
  input  wire logic                          rewalk_dir,
  input  wire logic                          rewalk_last
);
  import huff_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    CLEAR,
    FETCH,
    LEFT,
    RIGHT,
    BACKTRACK,
    REWALK,
    FINISH
  } state_t;

  state_t               state;
  state_t               next_state;
  state_t               fetch_ret;                // where FETCH goes once the node data is out
  state_t               next_ret;
  logic [NODE_ADDR_W-1:0] next_idx;
  logic [CHAR_W-1:0]    clr_addr;
  entry_t               child;
  logic                 emit;                     // a character child was found this cycle

  assign busy = (state != IDLE);
  assign done = (state == FINISH);

  always_comb begin
    next_state = state;
    next_ret = fetch_ret;
    next_idx = node_raddr;
    child = ENTRY_EMPTY;
    emit = 1'b0;
    clear = 1'b0;
    push = 1'b0;
    dir = 1'b0;
    pop = 1'b0;
    rewalk_start = 1'b0;
    rewalk_step = 1'b0;
    case (state)
      IDLE: begin
        if (start) begin
          clear = 1'b1;
          next_state = CLEAR;
        end
      end
      CLEAR: begin
        if (clr_addr == '1) begin                 // last codebook entry is being wiped
          next_idx = root;
          next_ret = LEFT;
          next_state = FETCH;
        end
      end
      FETCH: next_state = fetch_ret;
      LEFT, RIGHT: begin
        dir = (state == RIGHT);
        child = dir ? node_rdata.right : node_rdata.left;
        next_state = dir ? BACKTRACK : RIGHT;     // empty child falls through here
        if (entry_is_char(child)) begin
          emit = 1'b1;
        end else if (entry_is_node(child)) begin
          push = 1'b1;
          next_idx = child[NODE_ADDR_W-1:0];
          next_ret = LEFT;
          next_state = FETCH;
        end
      end
      BACKTRACK: begin
        if (depth == '0) begin
          next_state = FINISH;                    // back at the root with both sides done
        end else begin
          pop = 1'b1;
          if (!path[0]) begin                     // came from a left child, the right one is next
            rewalk_start = 1'b1;
            next_idx = root;
            next_ret = (depth == DEPTH_W'(1)) ? RIGHT : REWALK;
            next_state = FETCH;
          end
        end
      end
      REWALK: begin
        child = rewalk_dir ? node_rdata.right : node_rdata.left;
        rewalk_step = 1'b1;
        next_idx = child[NODE_ADDR_W-1:0];
        next_ret = rewalk_last ? RIGHT : REWALK;  // the last step lands on the parent
        next_state = FETCH;
      end
      FINISH: next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= IDLE;
      fetch_ret <= LEFT;
      node_raddr <= '0;
      clr_addr <= '0;
      cb_we <= 1'b0;
      codes <= '0;
    end else begin
      state <= next_state;
      fetch_ret <= next_ret;
      node_raddr <= next_idx;
      cb_we <= emit || (state == CLEAR);
      if (state == IDLE) begin
        clr_addr <= '0;
      end else if (state == CLEAR) begin
        clr_addr <= clr_addr + 1'b1;
      end
      if (state == IDLE && start) begin
        codes <= '0;
      end else if (emit) begin
        codes <= codes + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == CLEAR) begin
      cb_waddr <= clr_addr;
      cb_wdata <= '0;
    end else begin
      cb_waddr <= child[CHAR_W-1:0];
      cb_wdata.valid <= 1'b1;
      cb_wdata.len <= depth + 1'b1;
      cb_wdata.code <= {path[MAX_DEPTH-2:0], dir}; // the leaf step is the last code bit
    end
  end

endmodule

`default_nettype wire

/* hw/code_path.sv */
`default_nettype none

module code_path (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic                          clear,
  input  wire logic                          push,
  input  wire logic                          dir,
  input  wire logic                          pop,
  input  wire logic                          rewalk_start,
  input  wire logic                          rewalk_step,
  output logic [huff_pkg::MAX_DEPTH-1:0]     path,
  output logic [huff_pkg::DEPTH_W-1:0]       depth,
  output logic                               rewalk_dir,
  output logic                               rewalk_last
);
  import huff_pkg::*;

  logic [DEPTH_W-1:0] step;                       // 1 based step of the walk from the root
  logic [DEPTH_W-1:0] bit_pos;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      path <= '0;
      depth <= '0;
    end else if (clear) begin
      path <= '0;
      depth <= '0;
    end else if (push) begin
      path <= {path[MAX_DEPTH-2:0], dir};         // newest step sits in bit 0
      depth <= depth + 1'b1;
    end else if (pop) begin
      path <= path >> 1;
      depth <= depth - 1'b1;
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      step <= '0;
    end else if (clear) begin
      step <= '0;
    end else if (rewalk_start) begin
      step <= DEPTH_W'(1);
    end else if (rewalk_step) begin
      step <= step + 1'b1;
    end
  end

  // Step 1 is the oldest bit of the path, the last step is bit 0
  assign bit_pos = depth - step;
  assign rewalk_dir = path[bit_pos[$clog2(MAX_DEPTH)-1:0]];
  assign rewalk_last = (step == depth);

endmodule

`default_nettype wire

/* hw/sdp_ram.sv */
`default_nettype none

module sdp_ram #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 256
) (
  input  wire logic                     clk,
  input  wire logic                     we,
  input  wire logic [$clog2(DEPTH)-1:0] waddr,
  input  wire payload_t                 wdata,
  input  wire logic [$clog2(DEPTH)-1:0] raddr,
  output payload_t                      rdata
);

  payload_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];                          // a same-address write shows up one read later
  end

endmodule

`default_nettype wire

/* hw/huff_pkg.sv */
`default_nettype none

package huff_pkg;

  localparam int NODE_ADDR_W = 7;                 // 128 tree nodes
  localparam int CHAR_W = 8;                      // 256 codebook entries
  localparam int MAX_DEPTH = 16;                  // longest code the walker can build
  localparam int DEPTH_W = 5;
  localparam int NODE_COUNT = 1 << NODE_ADDR_W;
  localparam int CB_COUNT = 1 << CHAR_W;

  // child entry: bit 8 clear is a character, 10b + index is an internal node
  typedef logic [8:0] entry_t;

  localparam entry_t ENTRY_EMPTY = 9'h180;

  typedef struct packed {
    entry_t left;
    entry_t right;
  } node_t;

  typedef struct packed {
    logic                 valid;
    logic [DEPTH_W-1:0]   len;
    logic [MAX_DEPTH-1:0] code;                   // right aligned, first step in the top used bit
  } cb_entry_t;

  localparam logic [11:0] REG_CTRL = 12'h000;
  localparam logic [11:0] REG_STATUS = 12'h004;
  localparam logic [11:0] REG_ROOT = 12'h008;
  localparam logic [11:0] NODE_BASE = 12'h400;
  localparam logic [11:0] CB_BASE = 12'h800;

  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  function automatic logic entry_is_char(entry_t e);
    return !e[8];
  endfunction

  function automatic logic entry_is_node(entry_t e);
    return e[8] && !e[7];                         // anything else with bit 8 set counts as empty
  endfunction

endpackage

`default_nettype wire
